/* vlog.f */
source/dramPkg.sv
source/cpuBusPort.sv
source/dramSequencer.sv
source/sdramPinDriver.sv
source/m68kDramController.sv
verification/dramController_assert.sv
verification/m68kDramControllerTb.sv

/* Makefile */
TOP = m68kDramControllerTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir

/* verification/m68kDramControllerTb.sv */
`timescale 1ns/1ns
//////////////////////////////////////////////////////////////////////
// random 68000 bus cycles against a behavioral SDRAM and a word model
// addresses stay below 2^26 and reads of never-written words go unchecked
//////////////////////////////////////////////////////////////////////
module m68kDramControllerTb;

	localparam int busCycles = 200;
	localparam int initClocks = 400;                       // reset plus the init sequence
	localparam int refreshClocks = int'(dramPkg::refreshInterval);
	localparam int idleClocks = 2 * refreshClocks + 40;
	localparam int refreshLimit = refreshClocks + 20;
	localparam int dtackTimeout = 60;
	localparam int watchdogClocks = busCycles * 60 + initClocks + idleClocks;

	// pin codes {cke, csL, rasL, casL, weL} from the SDRAM truth table
	localparam logic [4:0] powerUpCode = 5'b00000;
	localparam logic [4:0] nopCode = 5'b10111;
	localparam logic [4:0] prechargeAllCode = 5'b10010;
	localparam logic [4:0] autoRefreshCode = 5'b10001;
	localparam logic [4:0] modeSetCode = 5'b10000;
	localparam logic [4:0] activateCode = 5'b10011;
	localparam logic [4:0] readApCode = 5'b10101;
	localparam logic [4:0] writeApCode = 5'b10100;

	logic Clock;
	logic Reset_L;
	logic [31:0] address;
	logic [15:0] dataIn;
	logic udsL, ldsL, dramSelectL, weL, asL;
	logic [15:0] dataOut;
	logic dtackL, resetOutL;
	logic sdramCke, sdramCsL, sdramRasL, sdramCasL, sdramWeL;
	logic [12:0] sdramAddr;
	logic [1:0] sdramBa;
	wire [15:0] sdramDq;

	int seed = 32'h7c15_5bb2;
	int errors = 0;
	int cycleCount = 0;

	logic [15:0] refMem [logic [24:0]];  // last word written per bank/row/column key
	logic [31:0] writtenAddr [$];

	m68kDramController dut (.*);

	initial begin
		Clock = 1'b0;
		forever #10 Clock = ~Clock;
	end

	//////////////////////////////////////////////////////////////////////
	// behavioral SDRAM with CAS latency 2 and no bursts

	logic [15:0] chipMem [logic [24:0]];
	logic [12:0] openRow [4];            // row opened per bank
	logic [15:0] readWord;
	logic chipDrive = 1'b0;
	int readDelay = 0;
	logic [4:0] pinCode;
	logic [4:0] lastCode = 5'h1f;        // no real command

	// command log where runs of one code collapse to one entry
	logic [4:0] logCode [$];
	logic [12:0] logAddr [$];
	logic [1:0] logBa [$];
	logic [15:0] logDq [$];
	int logCycle [$];

	assign pinCode = {sdramCke, sdramCsL, sdramRasL, sdramCasL, sdramWeL};
	assign sdramDq = chipDrive ? readWord : 'z;

	function automatic logic [24:0] wordKey(input logic [1:0] bank, input logic [12:0] row,
			input logic [9:0] col);
		return {bank, row, col};
	endfunction

	always @(posedge Clock) begin
		cycleCount <= cycleCount + 1;
		chipDrive <= (readDelay == 1);   // one cycle of read data
		if (readDelay != 0)
			readDelay <= readDelay - 1;
		if (pinCode != lastCode) begin
			logCode.push_back(pinCode);
			logAddr.push_back(sdramAddr);
			logBa.push_back(sdramBa);
			logDq.push_back(sdramDq);
			logCycle.push_back(cycleCount);
		end
		lastCode <= pinCode;
		case (pinCode)
			activateCode:
				openRow[sdramBa] = sdramAddr;
			writeApCode:
				chipMem[wordKey(sdramBa, openRow[sdramBa], sdramAddr[9:0])] = sdramDq;
			readApCode: begin
				readWord <= chipMem.exists(wordKey(sdramBa, openRow[sdramBa], sdramAddr[9:0])) ?
					chipMem[wordKey(sdramBa, openRow[sdramBa], sdramAddr[9:0])] : 16'h0000;
				readDelay <= int'(dramPkg::casLatency) - 1;  // data out from the next edge
			end
			default: ;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// helpers

	task automatic reportMismatch(input string testName, input logic [31:0] expected,
			input logic [31:0] actual);
		errors++;
		$display("ERR %s expected %h actual %h at %0t", testName, expected, actual, $time);
	endtask

	task automatic reportFailure(input string what);
		errors++;
		$display("failure at %0t: %s", $time, what);
	endtask

	task automatic driveSlot();
		@(posedge Clock);
		#2;                                  // inputs change just after the edge
	endtask

	task automatic checkInitSequence();
		logic [4:0] expectedCodes [$];
		logic [12:0] addrWord;
		int waitCount;
		expectedCodes.push_back(powerUpCode);
		expectedCodes.push_back(nopCode);
		expectedCodes.push_back(prechargeAllCode);
		expectedCodes.push_back(nopCode);
		repeat (10) begin
			expectedCodes.push_back(autoRefreshCode);
			expectedCodes.push_back(nopCode);
		end
		expectedCodes.push_back(modeSetCode);
		waitCount = 0;
		while (resetOutL !== 1'b1 && waitCount < initClocks) begin
			@(negedge Clock);
			waitCount++;
			assert (dtackL) else reportFailure("dtackL went low during initialisation");
		end
		assert (resetOutL) else reportFailure("resetOutL never rose after initialisation");
		assert (logCode.size() >= expectedCodes.size())
			else reportFailure("resetOutL rose before the mode register set");
		for (int i = 0; i < expectedCodes.size() && i < logCode.size(); i++)
			assert (logCode[i] == expectedCodes[i]) else reportMismatch(
				$sformatf("init command %0d", i), 32'(expectedCodes[i]), 32'(logCode[i]));
		if (logCode.size() >= expectedCodes.size()) begin
			addrWord = logAddr[2];
			assert (addrWord[10])
				else reportFailure("init precharge-all without address bit 10");
			assert (logAddr[24] == 13'h220)
				else reportMismatch("mode register value", 32'(13'h220), 32'(logAddr[24]));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// one CPU bus cycle starting 2 ns after a rising edge

	task automatic runBusCycle(input logic isWrite, input logic [31:0] addr,
			input logic [15:0] data, input logic [1:0] strobes);
		logic [24:0] key;
		logic haveRef;
		logic [15:0] refData;
		logic [4:0] expCode;
		int logStart;
		int waitCount;
		int holdCycles;
		int actIdx;
		int colIdx;
		key = wordKey(addr[25:24], addr[23:11], addr[10:1]);  // row 23:11, bank 25:24, col 10:1
		haveRef = refMem.exists(key);
		refData = haveRef ? refMem[key] : 16'h0000;
		logStart = logCode.size();
		address = addr;
		weL = !isWrite;
		dataIn = data;
		asL = 1'b0;
		dramSelectL = 1'b0;
		driveSlot();
		udsL = strobes[1];
		ldsL = strobes[0];
		waitCount = 0;
		@(negedge Clock);
		while (dtackL && waitCount < dtackTimeout) begin
			@(negedge Clock);
			waitCount++;
		end
		assert (!dtackL) else reportFailure($sformatf("no dtack for access at %h", addr));
		if (!isWrite && haveRef)
			assert (dataOut == refData)
				else reportMismatch("read data", 32'(refData), 32'(dataOut));
		holdCycles = $random(seed) & 3;
		repeat (holdCycles) begin          // dtack must hold while a strobe is low
			@(negedge Clock);
			assert (!dtackL) else reportFailure("dtackL rose while a strobe was still low");
		end
		driveSlot();
		if (strobes == 2'b00) begin        // upper lane lets go first
			udsL = 1'b1;
			driveSlot();
			@(negedge Clock);
			assert (!dtackL) else reportFailure("dtackL rose while ldsL was still low");
			driveSlot();
		end
		udsL = 1'b1;
		ldsL = 1'b1;
		asL = 1'b1;
		dramSelectL = 1'b1;
		waitCount = 0;
		@(negedge Clock);
		while (!dtackL && waitCount < 4) begin
			@(negedge Clock);
			waitCount++;
		end
		assert (dtackL) else reportFailure("dtackL stuck low after the strobes were released");
		if (isWrite) begin
			refMem[key] = data;
			writtenAddr.push_back(addr);
		end

		// address mapping and write data from the command log
		actIdx = -1;
		for (int i = logStart; i < logCode.size(); i++)
			if (actIdx < 0 && logCode[i] == activateCode)
				actIdx = i;
		assert (actIdx >= 0) else reportFailure($sformatf("no activate for access at %h", addr));
		if (actIdx >= 0) begin
			assert (logAddr[actIdx] == addr[23:11])
				else reportMismatch("activate row", 32'(addr[23:11]), 32'(logAddr[actIdx]));
			assert (logBa[actIdx] == addr[25:24])
				else reportMismatch("activate bank", 32'(addr[25:24]), 32'(logBa[actIdx]));
			colIdx = actIdx + 1;
			while (colIdx < logCode.size() && logCode[colIdx] == nopCode)
				colIdx++;
			expCode = isWrite ? writeApCode : readApCode;
			if (colIdx < logCode.size()) begin
				assert (logCode[colIdx] == expCode)
					else reportMismatch("column command", 32'(expCode), 32'(logCode[colIdx]));
				assert (logAddr[colIdx] == {2'b00, 1'b1, addr[10:1]}) else reportMismatch(
					"column address", 32'({2'b00, 1'b1, addr[10:1]}), 32'(logAddr[colIdx]));
				if (isWrite)
					assert (logDq[colIdx] == data)
						else reportMismatch("write data", 32'(data), 32'(logDq[colIdx]));
			end else begin
				reportFailure($sformatf("no column command after activate for %h", addr));
			end
		end
		driveSlot();
	endtask

	task automatic checkIdleRefresh();
		logic [4:0] prevCode;
		int logStart;
		int lastRefresh;
		int refreshes;
		logStart = logCode.size();
		lastRefresh = cycleCount;
		refreshes = 0;
		prevCode = (logStart > 0) ? logCode[logStart - 1] : nopCode;
		repeat (idleClocks) @(posedge Clock);
		@(negedge Clock);
		for (int i = logStart; i < logCode.size(); i++) begin
			if (logCode[i] != nopCode) begin
				if (logCode[i] == autoRefreshCode && prevCode == prechargeAllCode) begin
					assert (logCycle[i] - lastRefresh <= refreshLimit)
						else reportFailure("idle refresh came too late");
					lastRefresh = logCycle[i];
					refreshes++;
				end
				prevCode = logCode[i];
			end
		end
		assert (refreshes >= 2) else reportFailure("fewer than two refreshes while idle");
		assert (cycleCount - lastRefresh <= refreshLimit)
			else reportFailure("no refresh near the end of the idle window");
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence and watchdog

	initial begin
		logic [31:0] rnd;
		logic [31:0] addr;
		logic [1:0] strobes;
		int pick;
		address = '0;
		dataIn = '0;
		udsL = 1'b1;
		ldsL = 1'b1;
		dramSelectL = 1'b1;
		weL = 1'b1;
		asL = 1'b1;
		Reset_L = 1'b1;
		#1 Reset_L = 1'b0;
		repeat (3) @(posedge Clock);
		#2 Reset_L = 1'b1;
		checkInitSequence();
		driveSlot();
		for (int n = 0; n < busCycles; n++) begin
			rnd = $random(seed);
			addr = {6'b000000, rnd[25:0]};
			if (!rnd[31] && writtenAddr.size() > 0 && rnd[30]) begin  // reread an old word
				pick = int'(rnd[15:0]) % writtenAddr.size();
				addr = writtenAddr[pick];
			end
			strobes = (rnd[27:26] == 2'b11) ? 2'b00 : rnd[27:26];
			runBusCycle(rnd[31], addr, rnd[15:0] ^ rnd[29:14], strobes);
			repeat (rnd[20:18]) driveSlot();          // idle gap
		end
		checkIdleRefresh();
		errors += dut.pinDriver.pinChecks.failCount;
		$display("bus cycles %0d, errors %0d", busCycles, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial begin
		repeat (watchdogClocks) @(posedge Clock);
		$display("watchdog expired after %0d clocks, the run did not finish", watchdogClocks);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

/* verification/dramController_assert.sv */
`timescale 1ns/1ns
//////////////////////////////////////////////////////////////////////
// pin-level rules for the SDRAM output stage
// pin code is ordered {cke, csL, rasL, casL, weL} as in the package
//////////////////////////////////////////////////////////////////////
module pinDriverChecks (
	input logic Clock,
	input logic Reset_L,
	input logic sdramCke,
	input logic sdramCsL,
	input logic sdramRasL,
	input logic sdramCasL,
	input logic sdramWeL,
	input logic dtackL,
	input logic resetOutL,
	input logic driveDq
);

	int failCount = 0;
	logic [4:0] pinCode; // command now on the pins

	assign pinCode = {sdramCke, sdramCsL, sdramRasL, sdramCasL, sdramWeL};

	// dq driven in the write cycle and the one after it, never otherwise
	dqOnlyAroundWrite: assert property (@(posedge Clock) disable iff (!Reset_L)
		driveDq |-> (pinCode == dramPkg::writeApCmd) || ($past(pinCode) == dramPkg::writeApCmd))
		else begin
			failCount++;
			$error("dq driven outside a write command");
		end

	// no bus termination while the CPU sits in reset
	noDtackInReset: assert property (@(posedge Clock) disable iff (!Reset_L)
		!resetOutL |-> dtackL)
		else begin
			failCount++;
			$error("dtackL low while resetOutL is low");
		end

	// once the first NOP raised cke it never drops again
	ckeStaysHigh: assert property (@(posedge Clock) disable iff (!Reset_L)
		sdramCke |=> sdramCke)
		else begin
			failCount++;
			$error("cke dropped after power-up");
		end

endmodule

bind sdramPinDriver pinDriverChecks pinChecks (
	.Clock(Clock),
	.Reset_L(Reset_L),
	.sdramCke(sdramCke),
	.sdramCsL(sdramCsL),
	.sdramRasL(sdramRasL),
	.sdramCasL(sdramCasL),
	.sdramWeL(sdramWeL),
	.dtackL(dtackL),
	.resetOutL(resetOutL),
	.driveDq(driveDq)
);

/* source/m68kDramController.sv */
`timescale 1ns/1ns
//////////////////////////////////////////////////////////////////////
// 68000 bus to 16-bit SDRAM, one word per bus cycle, no byte masking
// UDS and LDS only time the cycle, every write stores the full word
//////////////////////////////////////////////////////////////////////
module m68kDramController (
	input  logic Clock,
	input  logic Reset_L,
	input  logic [31:0] address,
	input  logic [dramPkg::dataWidth-1:0] dataIn,
	input  logic udsL,
	input  logic ldsL,
	input  logic dramSelectL,
	input  logic weL,
	input  logic asL,
	output logic [dramPkg::dataWidth-1:0] dataOut,
	output logic dtackL,
	output logic resetOutL,
	output logic sdramCke,
	output logic sdramCsL,
	output logic sdramRasL,
	output logic sdramCasL,
	output logic sdramWeL,
	output logic [dramPkg::rowWidth-1:0] sdramAddr,
	output logic [dramPkg::bankWidth-1:0] sdramBa,
	inout  wire  [dramPkg::dataWidth-1:0] sdramDq
);

	// bus port to sequencer
	logic accessRequest;
	logic dataStrobe;
	logic [dramPkg::rowWidth-1:0] row;
	logic [dramPkg::colWidth-1:0] column;
	logic [dramPkg::bankWidth-1:0] bank;
	logic writeAccess;
	logic isIdle;                   // back from the sequencer, gates the capture

	// sequencer to pin driver
	dramPkg::sdramCommandT nextCommand;
	logic [dramPkg::rowWidth-1:0] nextAddr;
	logic [dramPkg::bankWidth-1:0] nextBa;
	logic driveData;
	logic latchRead;
	logic ackL;
	logic cpuReleaseL;

	// port names match the nets above
	cpuBusPort busPort (.*);
	dramSequencer sequencer (.*);
	sdramPinDriver pinDriver (.*);

endmodule

/* source/sdramPinDriver.sv */
`timescale 1ns/1ns
//////////////////////////////////////////////////////////////////////
// output register stage, pins lag the sequencer by one clock
// read data is caught on the falling edge, dq floats except for writes
//////////////////////////////////////////////////////////////////////
module sdramPinDriver (
	input  logic Clock,
	input  logic Reset_L,
	input  dramPkg::sdramCommandT nextCommand,
	input  logic [dramPkg::rowWidth-1:0] nextAddr,
	input  logic [dramPkg::bankWidth-1:0] nextBa,
	input  logic driveData,
	input  logic [dramPkg::dataWidth-1:0] dataIn,
	input  logic latchRead,
	input  logic ackL,
	input  logic cpuReleaseL,
	output logic sdramCke,
	output logic sdramCsL,
	output logic sdramRasL,
	output logic sdramCasL,
	output logic sdramWeL,
	output logic [dramPkg::rowWidth-1:0] sdramAddr,
	output logic [dramPkg::bankWidth-1:0] sdramBa,
	output logic dtackL,
	output logic resetOutL,
	output logic [dramPkg::dataWidth-1:0] dataOut,
	inout  wire  [dramPkg::dataWidth-1:0] sdramDq
);

	dramPkg::sdramCommandT command;               // command on the pins now
	logic [dramPkg::dataWidth-1:0] writeData;
	logic driveDq;                                // dq output enable

	//////////////////////////////////////////////////////////////////////
	// control pins

	always_ff @(posedge Clock, negedge Reset_L) begin
		if (!Reset_L) begin
			command.code <= dramPkg::powerUpCmd; // cke and cs low out of reset
			dtackL <= 1'b1;
			resetOutL <= 1'b0;                   // CPU held until init is done
			driveDq <= 1'b0;
		end else begin
			command <= nextCommand;
			dtackL <= ackL;
			resetOutL <= cpuReleaseL;
			driveDq <= driveData;
		end
	end

	assign sdramCke = command.pins.cke;
	assign sdramCsL = command.pins.csL;
	assign sdramRasL = command.pins.rasL;
	assign sdramCasL = command.pins.casL;
	assign sdramWeL = command.pins.weL;

	//////////////////////////////////////////////////////////////////////
	// address and data path

	always_ff @(posedge Clock) begin
		sdramAddr <= nextAddr;
		sdramBa <= nextBa;
		writeData <= dataIn; // lines up with the write command
	end

	assign sdramDq = driveDq ? writeData : 'z;

	// mid-cycle sample, the part drives the word after the CAS latency
	always_ff @(negedge Clock) begin
		if (latchRead)
			dataOut <= sdramDq;
	end

endmodule

/* source/dramSequencer.sv */
`timescale 1ns/1ns
//////////////////////////////////////////////////////////////////////
// init, periodic refresh and single-word read/write FSM
// a due refresh is served before a pending CPU access
// all outputs are next-cycle pin values, the pin driver registers them
//////////////////////////////////////////////////////////////////////
module dramSequencer (
	input  logic Clock,
	input  logic Reset_L,
	input  logic accessRequest,
	input  logic dataStrobe,
	input  logic [dramPkg::rowWidth-1:0] row,
	input  logic [dramPkg::colWidth-1:0] column,
	input  logic [dramPkg::bankWidth-1:0] bank,
	input  logic writeAccess,
	output logic isIdle,
	output dramPkg::sdramCommandT nextCommand,
	output logic [dramPkg::rowWidth-1:0] nextAddr,
	output logic [dramPkg::bankWidth-1:0] nextBa,
	output logic driveData,
	output logic latchRead,
	output logic ackL,
	output logic cpuReleaseL
);

	dramPkg::sequencerStateT state, nextState;

	logic [15:0] timer;        // power-up and CAS countdown
	logic [15:0] timerValue;
	logic timerLoad;
	logic timerDone;

	logic [15:0] refreshTimer; // idle clocks left until the next refresh
	logic refreshLoad;
	logic refreshDue;

	logic [2:0] nopCount;      // NOPs issued in the current wait loop
	logic nopLoop;
	logic nopDone;
	logic [3:0] refreshCount;  // init auto-refreshes issued
	logic released;            // CPU already let out of reset

	//////////////////////////////////////////////////////////////////////
	// timers

	always_ff @(posedge Clock, negedge Reset_L) begin
		if (!Reset_L) begin
			timer <= 16'd0;
		end else if (timerLoad) begin
			timer <= timerValue;
		end else if (timer != 16'd0) begin
			timer <= timer - 16'd1; // parks at zero
		end
	end
	assign timerDone = (timer == 16'd0);

	assign refreshLoad = (state == dramPkg::stateRefreshTimerLoad);
	always_ff @(posedge Clock, negedge Reset_L) begin
		if (!Reset_L) begin
			refreshTimer <= 16'd0;
		end else if (refreshLoad) begin
			refreshTimer <= dramPkg::refreshInterval;
		end else if (refreshTimer != 16'd0) begin
			refreshTimer <= refreshTimer - 16'd1;
		end
	end
	assign refreshDue = (refreshTimer == 16'd0);

	//////////////////////////////////////////////////////////////////////
	// counters and state register

	assign nopLoop = (state == dramPkg::stateRefreshNopLoop) ||
		(state == dramPkg::stateModeNop) || (state == dramPkg::stateRefNopLoop);
	assign nopDone = (nopCount == dramPkg::nopWaitCycles - 3'd1); // last NOP of the loop

	always_ff @(posedge Clock, negedge Reset_L) begin
		if (!Reset_L) begin
			state <= dramPkg::stateInit;
			nopCount <= 3'd0;
			refreshCount <= 4'd0;
			released <= 1'b0;
		end else begin
			state <= nextState;
			nopCount <= nopLoop ? nopCount + 3'd1 : 3'd0; // clears between loops
			if (state == dramPkg::stateInit)
				refreshCount <= 4'd0;
			else if (state == dramPkg::stateRefresh)
				refreshCount <= refreshCount + 4'd1; // counted as issued
			if (isIdle)
				released <= 1'b1; // sticky
		end
	end

	assign isIdle = (state == dramPkg::stateIdle);
	assign cpuReleaseL = released || isIdle; // high from the first idle cycle on

	//////////////////////////////////////////////////////////////////////
	// next state and next pin values

	always_comb begin
		nextState = state;
		nextCommand.code = dramPkg::nopCmd; // NOP unless a state says otherwise
		nextAddr = '0;
		nextBa = '0;
		timerLoad = 1'b0;
		timerValue = 16'd0;
		driveData = 1'b0;
		latchRead = 1'b0;
		ackL = 1'b1;

		case (state)
			dramPkg::stateInit: begin
				nextCommand.code = dramPkg::powerUpCmd;
				timerValue = dramPkg::powerUpCycles;
				timerLoad = 1'b1;
				nextState = dramPkg::statePowerWait;
			end
			dramPkg::statePowerWait: begin
				nextCommand.code = dramPkg::powerUpCmd; // cke still low
				if (timerDone)
					nextState = dramPkg::stateFirstNop;
			end
			dramPkg::stateFirstNop:
				nextState = dramPkg::statePrecharge;
			dramPkg::statePrecharge: begin
				nextCommand.code = dramPkg::prechargeAllCmd;
				nextAddr[dramPkg::autoPrechargeBit] = 1'b1; // all banks
				nextState = dramPkg::statePrechargeNop;
			end
			dramPkg::statePrechargeNop:
				nextState = dramPkg::stateRefresh;
			dramPkg::stateRefresh: begin
				nextCommand.code = dramPkg::autoRefreshCmd;
				nextState = dramPkg::stateRefreshNopLoop;
			end
			dramPkg::stateRefreshNopLoop:
				if (nopDone)
					nextState = dramPkg::stateRefreshCheck;
			dramPkg::stateRefreshCheck:
				if (refreshCount == dramPkg::initRefreshCount)
					nextState = dramPkg::stateModeReg;
				else
					nextState = dramPkg::stateRefresh;
			dramPkg::stateModeReg: begin
				nextCommand.code = dramPkg::modeSetCmd;
				nextAddr = dramPkg::modeRegisterValue; // ba stays 0
				nextState = dramPkg::stateModeNop;
			end
			dramPkg::stateModeNop:
				if (nopDone)
					nextState = dramPkg::stateRefreshTimerLoad;
			dramPkg::stateRefreshTimerLoad:
				nextState = dramPkg::stateIdle; // refresh timer reloads here
			dramPkg::stateIdle:
				if (refreshDue)
					nextState = dramPkg::stateRefPrecharge; // the access waits
				else if (accessRequest)
					nextState = dramPkg::stateActivate;

			// periodic refresh
			dramPkg::stateRefPrecharge: begin
				nextCommand.code = dramPkg::prechargeAllCmd;
				nextAddr[dramPkg::autoPrechargeBit] = 1'b1;
				nextState = dramPkg::stateRefNop;
			end
			dramPkg::stateRefNop:
				nextState = dramPkg::stateRefCommand;
			dramPkg::stateRefCommand: begin
				nextCommand.code = dramPkg::autoRefreshCmd;
				nextState = dramPkg::stateRefNopLoop;
			end
			dramPkg::stateRefNopLoop:
				if (nopDone)
					nextState = dramPkg::stateRefreshTimerLoad;

			// CPU access, row captured in the idle cycle
			dramPkg::stateActivate: begin
				nextCommand.code = dramPkg::activateCmd;
				nextAddr = row;
				nextBa = bank;
				nextState = writeAccess ? dramPkg::stateWrite : dramPkg::stateRead;
			end
			dramPkg::stateRead: begin
				nextCommand.code = dramPkg::readApCmd;
				nextAddr = dramPkg::rowWidth'(column);
				nextAddr[dramPkg::autoPrechargeBit] = 1'b1; // bank closes by itself
				nextBa = bank;
				timerValue = dramPkg::casLatency;
				timerLoad = 1'b1;
				nextState = dramPkg::stateCasWait;
			end
			dramPkg::stateCasWait:
				if (timerDone) begin
					latchRead = 1'b1; // data sampled on this cycle's falling edge
					nextState = dramPkg::stateTerminate;
				end
			dramPkg::stateWrite:
				if (dataStrobe) begin
					nextCommand.code = dramPkg::writeApCmd;
					nextAddr = dramPkg::rowWidth'(column);
					nextAddr[dramPkg::autoPrechargeBit] = 1'b1;
					nextBa = bank;
					driveData = 1'b1;
					ackL = 1'b0;
					nextState = dramPkg::stateWriteEnd;
				end
			dramPkg::stateWriteEnd: begin
				driveData = 1'b1; // hold dq one more clock
				ackL = 1'b0;
				nextState = dramPkg::stateTerminate;
			end
			dramPkg::stateTerminate:
				if (dataStrobe)
					ackL = 1'b0; // dtack stays until both strobes are high
				else
					nextState = dramPkg::stateIdle;
			default:
				nextState = dramPkg::stateInit;
		endcase
	end

endmodule

/* source/cpuBusPort.sv */
`timescale 1ns/1ns
//////////////////////////////////////////////////////////////////////
// CPU strobes are plain active-low levels with no handshake
// address fields are frozen while the sequencer is away from idle
//////////////////////////////////////////////////////////////////////
module cpuBusPort (
	input  logic Clock,
	input  logic Reset_L,
	input  logic [31:0] address,
	input  logic weL,
	input  logic dramSelectL,
	input  logic asL,
	input  logic udsL,
	input  logic ldsL,
	input  logic isIdle,
	output logic accessRequest,
	output logic dataStrobe,
	output logic [dramPkg::rowWidth-1:0] row,
	output logic [dramPkg::colWidth-1:0] column,
	output logic [dramPkg::bankWidth-1:0] bank,
	output logic writeAccess
);

	logic capture; // sample the bus this cycle

	assign accessRequest = !dramSelectL && !asL; // dram decoded and address valid
	assign dataStrobe = !udsL || !ldsL;          // either lane will do since writes store the full word
	assign capture = accessRequest && isIdle;

	// row, bank and column held from activate through the column phase
	always_ff @(posedge Clock) begin
		if (capture) begin
			row <= address[dramPkg::rowMsb:dramPkg::rowLsb];
			bank <= address[dramPkg::bankMsb:dramPkg::bankLsb];
			column <= address[dramPkg::colMsb:dramPkg::colLsb];
		end
	end

	// access direction latched with the address fields
	always_ff @(posedge Clock, negedge Reset_L) begin
		if (!Reset_L) begin
			writeAccess <= 1'b0;
		end else if (capture) begin
			writeAccess <= !weL; // weL low means a write
		end
	end

endmodule

/* source/dramPkg.sv */
//////////////////////////////////////////////////////////////////////
// shared types and constants for the 68000 SDRAM controller
// assumes a 50 MHz clock and a 32M x16 part with 4 banks, CAS latency 2
// powerUpCycles is cut down for simulation, silicon wants about 100 us
//////////////////////////////////////////////////////////////////////
package dramPkg;

	// 5-bit command word, ordered {cke, csL, rasL, casL, weL}
	typedef enum logic [4:0] {
		powerUpCmd      = 5'b00000, // cke and cs held low during power up
		nopCmd          = 5'b10111,
		prechargeAllCmd = 5'b10010, // needs a10 high
		autoRefreshCmd  = 5'b10001,
		modeSetCmd      = 5'b10000, // mode value on the address pins
		activateCmd     = 5'b10011, // row on address, bank on ba
		readApCmd       = 5'b10101, // column on address with a10 high
		writeApCmd      = 5'b10100  // same, data on dq in the same cycle
	} sdramCodeT;

	typedef struct packed {
		logic cke;  // clock enable, active high
		logic csL;  // chip select
		logic rasL;
		logic casL;
		logic weL;
	} sdramPinsT;

	// the sequencer picks a code, the pin driver drives the pin bits
	typedef union packed {
		sdramCodeT code;
		sdramPinsT pins;
	} sdramCommandT;

	typedef enum logic [4:0] {
		stateInit,            // load the power-up timer
		statePowerWait,
		stateFirstNop,
		statePrecharge,
		statePrechargeNop,
		stateRefresh,         // init auto-refresh
		stateRefreshNopLoop,
		stateRefreshCheck,    // ten done yet?
		stateModeReg,
		stateModeNop,
		stateRefreshTimerLoad,
		stateIdle,
		stateRefPrecharge,    // periodic refresh from idle
		stateRefNop,
		stateRefCommand,
		stateRefNopLoop,
		stateActivate,
		stateRead,
		stateCasWait,
		stateWrite,           // waits for a data strobe
		stateWriteEnd,
		stateTerminate        // hold dtack until strobes go away
	} sequencerStateT;

	//////////////////////////////////////////////////////////////////////
	// timing, in clocks
	localparam logic [15:0] powerUpCycles = 16'd8;
	localparam logic [15:0] refreshInterval = 16'd374; // ~7.5 us at 50 MHz
	localparam logic [2:0] nopWaitCycles = 3'd3;
	localparam logic [3:0] initRefreshCount = 4'd10;
	localparam logic [15:0] casLatency = 16'd2;
	localparam logic [12:0] modeRegisterValue = 13'h220; // burst 1, CL 2, single write

	//////////////////////////////////////////////////////////////////////
	// CPU address fields and widths
	localparam int rowLsb = 11;
	localparam int rowMsb = 23;
	localparam int bankLsb = 24;
	localparam int bankMsb = 25;
	localparam int colLsb = 1; // bit 0 is the byte lane, never reaches the part
	localparam int colMsb = 10;
	localparam int autoPrechargeBit = 10;

	localparam int dataWidth = 16;
	localparam int rowWidth = 13;
	localparam int bankWidth = 2;
	localparam int colWidth = 10;

endpackage
